//--- list.f
spi_frame_pkg.sv
spi_mode_pkg.sv
spi_shifter.sv
spi_master.sv
spi_slave.sv
spi_link_top.sv
tb_spi_link.sv

//--- run.sh
#!/bin/sh
# build and run the SPI link testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -f list.f --top tb_spi_link
./obj_dir/Vtb_spi_link | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
echo "simulation passed"

//--- spi_frame_pkg.sv
// Frame-level definitions shared by every block of the SPI link.
// Import inside a module body, or use scoped names in port lists.
package spi_frame_pkg;

	// bits per frame, MSB goes first on the wire
	localparam int frame_width = 8;

	// one frame of payload
	typedef logic [frame_width-1:0] spi_word_t;

	// counts sampled bits, must reach frame_width
	typedef logic [3:0] bit_cnt_t;

	// slowest divider the slave can follow
	// the slave sees sclk through a two-flop synchronizer plus an edge
	// detect stage, so each sclk phase must last at least four sys_clk cycles
	localparam logic [15:0] CLK_DIV_MIN = 16'd3;

endpackage

//--- spi_link_top.sv
// Point-to-point SPI link with master and slave wired back to back.
// CPOL and CPHA set the clock mode of both ends.
`timescale 1ns/1ps

module spi_link_top #(
	parameter spi_mode_pkg::spi_cpol_t CPOL = 1'b1,
	parameter spi_mode_pkg::spi_cpha_t CPHA = 1'b1
) (
	input  logic                     sys_clk,
	input  logic                     rst,
	input  logic                     cs_ctrl,	// low keeps the slave selected
	input  logic [15:0]              clk_div_val,
	input  logic                     wr_req,
	input  spi_frame_pkg::spi_word_t master_tx,
	input  spi_frame_pkg::spi_word_t slave_tx,
	output logic                     wr_ack,
	output spi_frame_pkg::spi_word_t master_rx,
	output logic                     re_ack,
	output spi_frame_pkg::spi_word_t slave_rx,
	output logic                     cs,	// brought out for idle checks
	output logic                     sclk
);

	logic mosi;
	logic miso;

	spi_master #(
		.CPOL        (CPOL),
		.CPHA        (CPHA)
	) ins_spi_master (
		.sys_clk     (sys_clk),
		.rst         (rst),
		.cs_ctrl     (cs_ctrl),
		.clk_div_val (clk_div_val),
		.wr_req      (wr_req),
		.data_tx     (master_tx),
		.miso        (miso),
		.cs          (cs),
		.sclk        (sclk),
		.mosi        (mosi),
		.wr_ack      (wr_ack),
		.data_rx     (master_rx)
	);

	spi_slave #(
		.CPOL        (CPOL),
		.CPHA        (CPHA)
	) ins_spi_slave (
		.sys_clk     (sys_clk),
		.rst         (rst),
		.cs          (cs),
		.sclk        (sclk),
		.mosi        (mosi),
		.data_tx     (slave_tx),
		.miso        (miso),
		.re_ack      (re_ack),
		.data_rx     (slave_rx)
	);

endmodule

//--- spi_master.sv
// SPI master. Divides sys_clk into sclk and runs one full-duplex frame per wr_req.
// cs follows cs_ctrl one cycle late and is held low until a running frame ends.
`timescale 1ns/1ps

module spi_master #(
	parameter spi_mode_pkg::spi_cpol_t CPOL = 1'b0,
	parameter spi_mode_pkg::spi_cpha_t CPHA = 1'b0
) (
	input  logic                     sys_clk,
	input  logic                     rst,
	input  logic                     cs_ctrl,	// level, low selects the slave
	input  logic [15:0]              clk_div_val,	// sclk half period minus one
	input  logic                     wr_req,	// one-cycle pulse
	input  spi_frame_pkg::spi_word_t data_tx,
	input  logic                     miso,
	output logic                     cs,
	output logic                     sclk,
	output logic                     mosi,
	output logic                     wr_ack,	// one-cycle pulse at frame end
	output spi_frame_pkg::spi_word_t data_rx
);
	import spi_frame_pkg::*;
	import spi_mode_pkg::*;

	localparam int frame_edges = 2 * frame_width;	// 16 sclk toggles

	logic        busy;
	logic [15:0] div_q;	// clamped divider for this frame
	logic [15:0] div_cnt;
	logic [4:0]  edge_cnt;	// toggles issued
	logic        done_seen;	// shifter already reported the last sample
	logic        accept;
	logic        tick;
	logic        edges_done;
	logic        fin;
	spi_edge_t   edge_kind;
	logic        sample_edge;
	logic        shift_edge;
	logic        tx_bit;
	logic        frame_done;
	spi_word_t   rx_word;

	assign accept     = wr_req && !busy && !cs;	// ignored while busy or deselected
	assign edges_done = (edge_cnt == 5'(frame_edges));
	assign tick       = busy && !edges_done && (div_cnt == div_q);
	assign edge_kind  = edge_cnt[0] ? EDGE_TRAILING : EDGE_LEADING;	// even toggles lead
	assign sample_edge = tick && is_sample_edge(CPHA, edge_kind);
	assign shift_edge  = tick && !is_sample_edge(CPHA, edge_kind);
	assign fin        = busy && edges_done && (done_seen || frame_done);
	assign mosi       = busy ? tx_bit : 1'b0;	// quiet between frames

	always_ff @(posedge sys_clk) begin
		if (accept) begin
			div_q <= (clk_div_val < CLK_DIV_MIN) ? CLK_DIV_MIN : clk_div_val;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			busy      <= 1'b0;
			div_cnt   <= '0;
			edge_cnt  <= '0;
			done_seen <= 1'b0;
			sclk      <= CPOL;	// idle level
			cs        <= 1'b1;
			wr_ack    <= 1'b0;
			data_rx   <= '0;
		end else begin
			wr_ack <= 1'b0;
			cs     <= (busy || accept) ? 1'b0 : cs_ctrl;	// no release mid frame
			if (accept) begin
				busy      <= 1'b1;
				div_cnt   <= '0;
				edge_cnt  <= '0;
				done_seen <= 1'b0;
			end else if (fin) begin
				busy    <= 1'b0;
				wr_ack  <= 1'b1;
				data_rx <= rx_word;	// held until next wr_ack
			end else if (busy) begin
				if (frame_done) begin
					done_seen <= 1'b1;	// cpha 0 finishes sampling one edge early
				end
				if (tick) begin
					div_cnt  <= '0;
					edge_cnt <= edge_cnt + 1'b1;
					sclk     <= ~sclk;
				end else if (!edges_done) begin
					div_cnt <= div_cnt + 1'b1;
				end
			end
		end
	end

	spi_shifter #(
		.CPHA        (CPHA)
	) ins_spi_shifter (
		.sys_clk     (sys_clk),
		.rst         (rst),
		.load        (accept),
		.load_data   (data_tx),
		.sample_edge (sample_edge),
		.shift_edge  (shift_edge),
		.serial_in   (miso),
		.serial_out  (tx_bit),
		.rx_data     (rx_word),
		.frame_done  (frame_done)
	);

endmodule

//--- spi_mode_pkg.sv
// SPI clock-mode types and the sample/shift rule used by master, slave and shifter.
// Leading edge is the first sclk edge away from the idle level CPOL.
package spi_mode_pkg;

	typedef logic spi_cpol_t;	// sclk idle level
	typedef logic spi_cpha_t;	// which edge samples

	// edge position inside one sclk period
	typedef enum logic {
		EDGE_LEADING  = 1'b0,	// leaves idle level
		EDGE_TRAILING = 1'b1	// returns to idle level
	} spi_edge_t;

	// CPHA 0 samples on leading and shifts on trailing
	// CPHA 1 shifts on leading and samples on trailing
	function automatic logic is_sample_edge(spi_cpha_t cpha, spi_edge_t kind);
		logic on_lead;
		on_lead = (kind == EDGE_LEADING);
		return (cpha == 1'b0) ? on_lead : !on_lead;
	endfunction

endpackage

//--- spi_shifter.sv
// Frame shift engine shared by the SPI master and slave.
// Loads a word, shifts it out MSB first and samples the incoming bit stream.
`timescale 1ns/1ps

module spi_shifter #(
	parameter spi_mode_pkg::spi_cpha_t CPHA = 1'b0
) (
	input  logic                     sys_clk,
	input  logic                     rst,
	input  logic                     load,		// start of frame
	input  spi_frame_pkg::spi_word_t load_data,	// word to send
	input  logic                     sample_edge,	// capture serial_in
	input  logic                     shift_edge,	// advance serial_out
	input  logic                     serial_in,
	output logic                     serial_out,
	output spi_frame_pkg::spi_word_t rx_data,
	output logic                     frame_done	// eighth bit sampled
);
	import spi_frame_pkg::*;

	spi_word_t tx_sr;	// outgoing bits
	spi_word_t rx_sr;	// incoming bits
	bit_cnt_t  bit_cnt;	// bits sampled so far
	logic      last_bit;
	logic      shift_ok;

	assign last_bit = (bit_cnt == bit_cnt_t'(frame_width - 1));

	// with CPHA 1 the first leading edge finds the count at zero and is skipped
	// with CPHA 0 the trailing edge after the eighth sample must not move the data
	assign shift_ok = CPHA ? (bit_cnt != '0)
	                       : (bit_cnt != '0) && (bit_cnt != bit_cnt_t'(frame_width));

	assign serial_out = tx_sr[frame_width-1];	// msb first
	assign rx_data    = rx_sr;

	always_ff @(posedge sys_clk) begin
		if (load) begin
			tx_sr <= load_data;
		end else if (shift_edge && shift_ok) begin
			tx_sr <= {tx_sr[frame_width-2:0], 1'b0};
		end
		if (sample_edge) begin
			rx_sr <= {rx_sr[frame_width-2:0], serial_in};	// fill from lsb
		end
	end

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			bit_cnt    <= '0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			if (load) begin
				bit_cnt <= '0;
			end else if (sample_edge && (bit_cnt != bit_cnt_t'(frame_width))) begin
				bit_cnt    <= bit_cnt + 1'b1;
				frame_done <= last_bit;	// rx_sr is full next cycle
			end
		end
	end

endmodule

//--- spi_slave.sv
// SPI slave running on sys_clk. Bus pins pass through two-flop synchronizers
// and sclk edges are found from the synchronized level.
// The reply word is taken from data_tx at cs fall and after every frame.
`timescale 1ns/1ps

module spi_slave #(
	parameter spi_mode_pkg::spi_cpol_t CPOL = 1'b0,
	parameter spi_mode_pkg::spi_cpha_t CPHA = 1'b0
) (
	input  logic                     sys_clk,
	input  logic                     rst,
	input  logic                     cs,
	input  logic                     sclk,
	input  logic                     mosi,
	input  spi_frame_pkg::spi_word_t data_tx,	// next reply
	output logic                     miso,
	output logic                     re_ack,	// one-cycle pulse per frame
	output spi_frame_pkg::spi_word_t data_rx
);
	import spi_frame_pkg::*;
	import spi_mode_pkg::*;

	logic [2:0] sync1;	// {cs, sclk, mosi} first stage
	logic [2:0] sync2;	// second stage, safe to use
	logic [1:0] hist;	// {cs, sclk} one cycle older
	logic       cs_s;
	logic       sclk_s;
	logic       mosi_s;
	logic       cs_fall;
	logic       sclk_rise;
	logic       sclk_fall;
	logic       lead;
	logic       trail;
	logic       sample_edge;
	logic       shift_edge;
	logic       load;
	logic       tx_bit;
	logic       frame_done;
	spi_word_t  rx_word;

	assign {cs_s, sclk_s, mosi_s} = sync2;

	assign cs_fall   = hist[1] && !cs_s;
	assign sclk_rise = sclk_s && !hist[0];
	assign sclk_fall = !sclk_s && hist[0];

	// idle high means the frame opens on a falling edge
	assign lead  = !cs_s && (CPOL ? sclk_fall : sclk_rise);
	assign trail = !cs_s && (CPOL ? sclk_rise : sclk_fall);

	assign sample_edge = (lead && is_sample_edge(CPHA, EDGE_LEADING)) ||
	                     (trail && is_sample_edge(CPHA, EDGE_TRAILING));
	assign shift_edge  = (lead || trail) && !sample_edge;

	assign load = cs_fall || frame_done;	// reply ready before next frame
	assign miso = cs_s ? 1'b0 : tx_bit;	// driven low when deselected

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			sync1 <= {1'b1, CPOL, 1'b0};	// bus idle levels
			sync2 <= {1'b1, CPOL, 1'b0};
			hist  <= {1'b1, CPOL};
		end else begin
			sync1 <= {cs, sclk, mosi};
			sync2 <= sync1;
			hist  <= sync2[2:1];
		end
	end

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			re_ack  <= 1'b0;
			data_rx <= '0;
		end else begin
			re_ack <= frame_done;
			if (frame_done) begin
				data_rx <= rx_word;	// valid with re_ack
			end
		end
	end

	spi_shifter #(
		.CPHA        (CPHA)
	) ins_spi_shifter (
		.sys_clk     (sys_clk),
		.rst         (rst),
		.load        (load),
		.load_data   (data_tx),
		.sample_edge (sample_edge),
		.shift_edge  (shift_edge),
		.serial_in   (mosi_s),
		.serial_out  (tx_bit),
		.rx_data     (rx_word),
		.frame_done  (frame_done)
	);

endmodule

//--- tb_spi_link.sv
// Directed testbench for the SPI link in mode 3 (CPOL 1, CPHA 1).
// Runs reset, single exchange, echo chain, random and gated-request tests.
// The slave reply model follows the cs-fall and end-of-frame load rule.
`timescale 1ns/1ps

module tb_spi_link;
	import spi_frame_pkg::*;

	localparam int clk_period   = 20;
	localparam int drive_delay  = 2;	// after rising edge
	localparam int reset_cycles = 5;
	localparam int sync_settle  = 4;	// cs register plus slave sync and edge stage
	localparam int div_slow     = 49;
	localparam int div_fast_max = 20;
	localparam int gate_cycles  = 40 * (div_slow + 1);
	// 6 slow frames, 20 fast frames, gated window, per-frame overhead, margin
	localparam int wd_cycles = 6 * 16 * (div_slow + 1) + 20 * 16 * (div_fast_max + 1)
	                         + gate_cycles + 26 * 40 + 1000;

	logic        sys_clk;
	logic        rst;
	logic        cs_ctrl;
	logic [15:0] clk_div_val;
	logic        wr_req;
	spi_word_t   master_tx;
	spi_word_t   slave_tx;
	logic        wr_ack;
	spi_word_t   master_rx;
	logic        re_ack;
	spi_word_t   slave_rx;
	logic        cs;
	logic        sclk;

	logic [15:0] lfsr_state;
	spi_word_t   next_reply;	// word the slave shifts out in the next frame
	spi_word_t   last_master;
	spi_word_t   last_slave;

	spi_link_top #(
		.CPOL        (1'b1),
		.CPHA        (1'b1)
	) uut (
		.sys_clk     (sys_clk),
		.rst         (rst),
		.cs_ctrl     (cs_ctrl),
		.clk_div_val (clk_div_val),
		.wr_req      (wr_req),
		.master_tx   (master_tx),
		.slave_tx    (slave_tx),
		.wr_ack      (wr_ack),
		.master_rx   (master_rx),
		.re_ack      (re_ack),
		.slave_rx    (slave_rx),
		.cs          (cs),
		.sclk        (sclk)
	);

	initial begin
		sys_clk = 1'b0;
		forever #(clk_period / 2) sys_clk = ~sys_clk;
	end

	// galois form, taps 16,14,13,11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [15:0] value);
		int i;
		value = '0;
		for (i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);	// one step per bit
			value      = {value[14:0], lfsr_state[0]};
		end
	endtask

	task automatic stop_run(input string what);
		$display("%s", what);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped after an error");
	endtask

	task automatic check_value(input string test_name, input logic [15:0] expected,
	                           input logic [15:0] actual);
		if (actual !== expected) begin
			stop_run($sformatf("Fail %s expected %h actual %h", test_name, expected, actual));
		end
	endtask

	task automatic next_slot;
		@(posedge sys_clk);
		#(drive_delay);
	endtask

	task automatic check_idle(input string name);
		check_value({name, " cs"}, 16'h0001, 16'(cs));
		check_value({name, " sclk"}, 16'h0001, 16'(sclk));	// cpol 1
		check_value({name, " wr_ack"}, 16'h0000, 16'(wr_ack));
		check_value({name, " re_ack"}, 16'h0000, 16'(re_ack));
		check_value({name, " master_rx"}, 16'h0000, 16'(master_rx));
		check_value({name, " slave_rx"}, 16'h0000, 16'(slave_rx));
	endtask

	task automatic deselect_slave;
		next_slot();
		cs_ctrl = 1'b1;
		@(negedge sys_clk);
		while (cs !== 1'b1) @(negedge sys_clk);
		repeat (sync_settle) @(negedge sys_clk);	// slave sees cs high
	endtask

	// slave takes its first reply at the cs fall
	task automatic select_slave(input spi_word_t reply);
		next_slot();
		slave_tx = reply;
		cs_ctrl  = 1'b0;
		@(negedge sys_clk);
		while (cs !== 1'b0) @(negedge sys_clk);
		repeat (sync_settle) @(negedge sys_clk);
		next_reply = reply;
	endtask

	// one frame, then both sides checked against the exchange model
	task automatic run_frame(input string name, input int div, input spi_word_t m_tx,
	                         input spi_word_t s_tx);
		logic      seen_wr;
		logic      seen_re;
		spi_word_t got_m;
		spi_word_t got_s;
		next_slot();
		clk_div_val = 16'(div);
		master_tx   = m_tx;
		slave_tx    = s_tx;	// loaded by the slave at this frame's end
		wr_req      = 1'b1;
		next_slot();
		wr_req  = 1'b0;
		seen_wr = 1'b0;
		seen_re = 1'b0;
		got_m   = '0;
		got_s   = '0;
		while (!(seen_wr && seen_re)) begin
			@(negedge sys_clk);
			if (wr_ack) begin
				seen_wr = 1'b1;
				got_m   = master_rx;
			end
			if (re_ack) begin
				seen_re = 1'b1;
				got_s   = slave_rx;
			end
		end
		check_value({name, " master_rx"}, 16'(next_reply), 16'(got_m));
		check_value({name, " slave_rx"}, 16'(m_tx), 16'(got_s));
		next_reply  = s_tx;
		last_master = got_m;
		last_slave  = got_s;
	endtask

	task automatic test_reset_idle;
		repeat (reset_cycles) begin
			next_slot();
			check_idle("reset idle, rst high");
		end
		rst = 1'b0;
		repeat (10) begin
			@(negedge sys_clk);
			check_idle("reset idle, rst low");
		end
	endtask

	task automatic test_single_exchange;
		select_slave(8'h3c);
		run_frame("single exchange", div_slow, 8'ha5, 8'h3c);
	endtask

	task automatic test_echo_chain;
		int k;
		deselect_slave();
		select_slave(last_slave + 8'd2);
		for (k = 0; k < 5; k++) begin
			run_frame($sformatf("echo frame %0d", k), div_slow,
			          last_master + 8'd1, last_slave + 8'd2);
		end
	endtask

	task automatic test_random;
		int k;
		logic [15:0] v;
		logic [15:0] m;
		logic [15:0] s;
		deselect_slave();
		take_bits(8, v);
		select_slave(v[7:0]);
		for (k = 0; k < 20; k++) begin
			take_bits(5, v);	// divider 3..20
			take_bits(8, m);
			take_bits(8, s);
			run_frame($sformatf("random frame %0d", k), 3 + int'(v) % 18, m[7:0], s[7:0]);
		end
	endtask

	task automatic test_gated_request;
		deselect_slave();
		next_slot();
		clk_div_val = 16'(div_slow);
		master_tx   = 8'hff;
		wr_req      = 1'b1;
		next_slot();
		wr_req = 1'b0;
		repeat (gate_cycles) begin
			@(negedge sys_clk);
			if (cs !== 1'b1)
				stop_run("gated request: cs went low while cs_ctrl was high");
			if (sclk !== 1'b1)
				stop_run("gated request: sclk left its idle level");
			if (wr_ack !== 1'b0)
				stop_run("gated request: wr_ack pulsed for an ignored request");
			if (re_ack !== 1'b0)
				stop_run("gated request: re_ack pulsed with no frame on the bus");
		end
	endtask

	initial begin
		#(wd_cycles * clk_period);
		stop_run("watchdog expired, a test did not finish in time");
	end

	initial begin
		rst         = 1'b1;
		cs_ctrl     = 1'b1;	// deselected
		clk_div_val = 16'(div_slow);
		wr_req      = 1'b0;
		master_tx   = '0;
		slave_tx    = '0;
		lfsr_state  = 16'd23588;
		next_reply  = '0;
		last_master = '0;
		last_slave  = '0;
		test_reset_idle();
		test_single_exchange();
		test_echo_chain();
		test_random();
		test_gated_request();
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule
